// File: include/ram_cfg.svh
// memory front end sizes and port delays, included by the RTL and the testbench
`ifndef RAM_CFG_SVH
`define RAM_CFG_SVH

// main memory and video word width
`define RAM_DATA_W 32

// main port word address width
`define SDRAM_ADDR_W 22

// populated low address bits of main memory
// any set bit above these means out of range
`define SDRAM_POP_W 17

// byte address width on the DDR application side
`define APP_ADDR_W 28

// video word address width
`define VRAM_ADDR_W 15

// processor video port, request to ready
`define VRAM_CPU_DELAY 4

// display port, request to ready
`define VRAM_VGA_DELAY 1

`endif

// File: hdl/ram_pkg.sv
// shared types of the memory front end, imported by the sequencer and the DDR model
package ram_pkg;

   ////////////////////////////////////////
   // sequencer states
   ////////////////////////////////////////

   // one hot, one bit per state
   typedef enum logic [6:0] {
      st_idle       = 7'b0000001,
      st_read       = 7'b0000010,
      st_read_busy  = 7'b0000100,
      st_read_wait  = 7'b0001000,
      st_write      = 7'b0010000,
      st_write_busy = 7'b0100000,
      st_write_wait = 7'b1000000
   } sdram_state_t;

   ////////////////////////////////////////
   // application interface commands
   ////////////////////////////////////////

   // DDR controller encoding
   typedef enum logic [2:0] {
      app_cmd_write = 3'b000,
      app_cmd_read  = 3'b001
   } app_cmd_t;

endpackage

// File: hdl/sdram_sequencer.sv
// main memory sequencer, turns held word requests into DDR application commands
`timescale 1ns/1ps
`include "ram_cfg.svh"

module sdram_sequencer
   import ram_pkg::*;
(
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     calib_done,
   // main port
   input  logic [`SDRAM_ADDR_W-1:0] sdram_addr,
   input  logic [`RAM_DATA_W-1:0]   sdram_data_in,
   input  logic                     sdram_req,
   input  logic                     sdram_write,
   output logic [`RAM_DATA_W-1:0]   sdram_data_out,
   output logic                     sdram_ready,
   output logic                     sdram_done,
   // application interface
   output logic [`APP_ADDR_W-1:0]   app_addr,
   output app_cmd_t                 app_cmd,
   output logic                     app_en,
   output logic [`RAM_DATA_W-1:0]   app_wdf_data,
   output logic                     app_wdf_wren,
   input  logic                     app_rdy,
   input  logic                     app_wdf_rdy,
   input  logic [`RAM_DATA_W-1:0]   app_rd_data,
   input  logic                     app_rd_data_valid
);

   sdram_state_t state;
   sdram_state_t state_next;
   // latched in idle, holds for the whole access
   logic         out_of_range;
   logic         addr_high;
   // write data went out before the command was taken
   logic         wdf_taken;
   logic         wdf_accept;

   ////////////////////////////////////////
   // address and command
   ////////////////////////////////////////

   // any bit above the populated region
   assign addr_high = |sdram_addr[`SDRAM_ADDR_W-1:`SDRAM_POP_W];

   // word address to byte address, zero extended
   assign app_addr = {{(`APP_ADDR_W - `SDRAM_ADDR_W - 2){1'b0}}, sdram_addr, 2'b00};
   assign app_cmd = (state == st_write) ? app_cmd_write : app_cmd_read;
   assign app_wdf_data = sdram_data_in;

   // command held until app_rdy, never for an out of range access
   assign app_en = ((state == st_read) || (state == st_write)) && !out_of_range;

   // raised together with app_en, dropped on its own acceptance
   assign app_wdf_wren = ((state == st_write) && !out_of_range && !wdf_taken) ||
                         (state == st_write_busy);
   assign wdf_accept = app_wdf_wren && app_wdf_rdy;

   ////////////////////////////////////////
   // next state
   ////////////////////////////////////////

   always_comb begin
      state_next = state;
      case (state)
         st_idle: begin
            // nothing starts before calibration
            if (calib_done && sdram_req) begin
               state_next = st_read;
            end else if (calib_done && sdram_write) begin
               state_next = st_write;
            end
         end
         st_read: begin
            // out of range skips the controller
            if (out_of_range) begin
               state_next = st_read_wait;
            end else if (app_rdy) begin
               state_next = st_read_busy;
            end
         end
         st_read_busy: begin
            // latency varies, wait for the data beat
            if (app_rd_data_valid) begin
               state_next = st_read_wait;
            end
         end
         st_read_wait: begin
            if (!sdram_req) begin
               state_next = st_idle;
            end
         end
         st_write: begin
            if (out_of_range) begin
               state_next = st_write_wait;
            end else if (app_rdy) begin
               // command taken, data may still be pending
               state_next = (wdf_taken || app_wdf_rdy) ? st_write_wait : st_write_busy;
            end
         end
         st_write_busy: begin
            if (app_wdf_rdy) begin
               state_next = st_write_wait;
            end
         end
         st_write_wait: begin
            if (!sdram_write) begin
               state_next = st_idle;
            end
         end
         default: begin
            state_next = st_idle;
         end
      endcase
   end

   ////////////////////////////////////////
   // state and handshake registers
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= st_idle;
         out_of_range <= 1'b0;
         wdf_taken <= 1'b0;
         sdram_ready <= 1'b0;
         sdram_done <= 1'b0;
         sdram_data_out <= '0;
      end else begin
         state <= state_next;
         // range check and data flag restart every access
         if (state == st_idle) begin
            out_of_range <= addr_high;
            wdf_taken <= 1'b0;
         end else if (wdf_accept) begin
            wdf_taken <= 1'b1;
         end
         // read word, all ones above the populated region
         if ((state == st_read) && out_of_range) begin
            sdram_data_out <= '1;
         end else if ((state == st_read_busy) && app_rd_data_valid) begin
            sdram_data_out <= app_rd_data;
         end
         // ready and done stay up until the master lets go
         sdram_ready <= (state_next == st_read_wait);
         sdram_done <= (state_next == st_write_wait);
      end
   end

endmodule

// File: hdl/vram_dual_port.sv
// video RAM with a processor read/write port and a display read port, fixed ready delays
`timescale 1ns/1ps
`include "ram_cfg.svh"

module vram_dual_port (
   input  logic                    clk,
   input  logic                    reset,
   // processor port
   input  logic [`VRAM_ADDR_W-1:0] vram_cpu_addr,
   input  logic [`RAM_DATA_W-1:0]  vram_cpu_data_in,
   input  logic                    vram_cpu_req,
   input  logic                    vram_cpu_write,
   output logic [`RAM_DATA_W-1:0]  vram_cpu_data_out,
   output logic                    vram_cpu_ready,
   // display port
   input  logic [`VRAM_ADDR_W-1:0] vram_vga_addr,
   input  logic                    vram_vga_req,
   output logic [`RAM_DATA_W-1:0]  vram_vga_data_out,
   output logic                    vram_vga_ready
);

   logic [`RAM_DATA_W-1:0]    mem [0:(1 << `VRAM_ADDR_W)-1];
   logic [`VRAM_CPU_DELAY-1:0] cpu_ready_dly;
   logic [`VRAM_VGA_DELAY-1:0] vga_ready_dly;
   // raw display read, valid while ready is up
   logic [`RAM_DATA_W-1:0]    vga_ram_out;
   // last word the display saw
   logic [`RAM_DATA_W-1:0]    vga_hold;

   ////////////////////////////////////////
   // processor port
   ////////////////////////////////////////

   // write lands at the end of the request cycle
   // read is read first, registered one cycle later
   always_ff @(posedge clk) begin
      if (vram_cpu_req) begin
         if (vram_cpu_write) begin
            mem[vram_cpu_addr] <= vram_cpu_data_in;
         end
         vram_cpu_data_out <= mem[vram_cpu_addr];
      end
   end

   // req shifted through, oldest bit is ready
   always_ff @(posedge clk) begin
      if (reset) begin
         cpu_ready_dly <= '0;
      end else begin
         cpu_ready_dly[0] <= vram_cpu_req;
         for (int i = 1; i < `VRAM_CPU_DELAY; i++) begin
            cpu_ready_dly[i] <= cpu_ready_dly[i-1];
         end
      end
   end

   assign vram_cpu_ready = cpu_ready_dly[`VRAM_CPU_DELAY-1];

   ////////////////////////////////////////
   // display port
   ////////////////////////////////////////

   // read only, no write path
   always_ff @(posedge clk) begin
      if (vram_vga_req) begin
         vga_ram_out <= mem[vram_vga_addr];
      end
   end

   // same shifter, shorter
   always_ff @(posedge clk) begin
      if (reset) begin
         vga_ready_dly <= '0;
      end else begin
         vga_ready_dly[0] <= vram_vga_req;
         for (int i = 1; i < `VRAM_VGA_DELAY; i++) begin
            vga_ready_dly[i] <= vga_ready_dly[i-1];
         end
      end
   end

   assign vram_vga_ready = vga_ready_dly[`VRAM_VGA_DELAY-1];

   // capture every word shown while ready
   always_ff @(posedge clk) begin
      if (reset) begin
         vga_hold <= '0;
      end else if (vram_vga_ready) begin
         vga_hold <= vga_ram_out;
      end
   end

   // live RAM word while ready, otherwise the held one
   assign vram_vga_data_out = vram_vga_ready ? vga_ram_out : vga_hold;

endmodule

// File: hdl/ram_controller.sv
// memory front end top level, main memory sequencer plus video RAM on one clock
`timescale 1ns/1ps
`include "ram_cfg.svh"

module ram_controller
   import ram_pkg::*;
(
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     calib_done,
   // main port
   input  logic [`SDRAM_ADDR_W-1:0] sdram_addr,
   input  logic [`RAM_DATA_W-1:0]   sdram_data_in,
   input  logic                     sdram_req,
   input  logic                     sdram_write,
   output logic [`RAM_DATA_W-1:0]   sdram_data_out,
   output logic                     sdram_ready,
   output logic                     sdram_done,
   // DDR application interface
   output logic [`APP_ADDR_W-1:0]   app_addr,
   output app_cmd_t                 app_cmd,
   output logic                     app_en,
   output logic [`RAM_DATA_W-1:0]   app_wdf_data,
   output logic                     app_wdf_wren,
   input  logic                     app_rdy,
   input  logic                     app_wdf_rdy,
   input  logic [`RAM_DATA_W-1:0]   app_rd_data,
   input  logic                     app_rd_data_valid,
   // video, processor side
   input  logic [`VRAM_ADDR_W-1:0]  vram_cpu_addr,
   input  logic [`RAM_DATA_W-1:0]   vram_cpu_data_in,
   input  logic                     vram_cpu_req,
   input  logic                     vram_cpu_write,
   output logic [`RAM_DATA_W-1:0]   vram_cpu_data_out,
   output logic                     vram_cpu_ready,
   // video, display side
   input  logic [`VRAM_ADDR_W-1:0]  vram_vga_addr,
   input  logic                     vram_vga_req,
   output logic [`RAM_DATA_W-1:0]   vram_vga_data_out,
   output logic                     vram_vga_ready
);

   ////////////////////////////////////////
   // main memory
   ////////////////////////////////////////

   sdram_sequencer seq0 (
      .clk               (clk),
      .reset             (reset),
      .calib_done        (calib_done),
      .sdram_addr        (sdram_addr),
      .sdram_data_in     (sdram_data_in),
      .sdram_req         (sdram_req),
      .sdram_write       (sdram_write),
      .sdram_data_out    (sdram_data_out),
      .sdram_ready       (sdram_ready),
      .sdram_done        (sdram_done),
      .app_addr          (app_addr),
      .app_cmd           (app_cmd),
      .app_en            (app_en),
      .app_wdf_data      (app_wdf_data),
      .app_wdf_wren      (app_wdf_wren),
      .app_rdy           (app_rdy),
      .app_wdf_rdy       (app_wdf_rdy),
      .app_rd_data       (app_rd_data),
      .app_rd_data_valid (app_rd_data_valid)
   );

   ////////////////////////////////////////
   // video memory
   ////////////////////////////////////////

   vram_dual_port vram0 (
      .clk               (clk),
      .reset             (reset),
      .vram_cpu_addr     (vram_cpu_addr),
      .vram_cpu_data_in  (vram_cpu_data_in),
      .vram_cpu_req      (vram_cpu_req),
      .vram_cpu_write    (vram_cpu_write),
      .vram_cpu_data_out (vram_cpu_data_out),
      .vram_cpu_ready    (vram_cpu_ready),
      .vram_vga_addr     (vram_vga_addr),
      .vram_vga_req      (vram_vga_req),
      .vram_vga_data_out (vram_vga_data_out),
      .vram_vga_ready    (vram_vga_ready)
   );

endmodule

// File: dv/ddr_app_model.sv
// DDR application interface stand-in for simulation, word memory with random stalls and latency
`timescale 1ns/1ps
`include "ram_cfg.svh"

module ddr_app_model
   import ram_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic [`APP_ADDR_W-1:0] app_addr,
   input  app_cmd_t               app_cmd,
   input  logic                   app_en,
   input  logic [`RAM_DATA_W-1:0] app_wdf_data,
   input  logic                   app_wdf_wren,
   output logic                   app_rdy,
   output logic                   app_wdf_rdy,
   output logic [`RAM_DATA_W-1:0] app_rd_data,
   output logic                   app_rd_data_valid
);

   logic [`RAM_DATA_W-1:0] mem [logic [`APP_ADDR_W-1:0]];
   logic [31:0]            rng;
   // write command and write data may be taken on different cycles
   logic                   wr_cmd_pend;
   logic                   wr_data_pend;
   logic [`APP_ADDR_W-1:0] wr_addr;
   logic [`RAM_DATA_W-1:0] wr_data;
   logic                   rd_busy;
   logic [2:0]             rd_count;
   logic [`APP_ADDR_W-1:0] rd_addr;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // never written words, all address bits show up
   function automatic logic [31:0] fill_word(input logic [`APP_ADDR_W-1:0] a);
      return {a, 4'h0} ^ 32'hc3a5_0f1e;
   endfunction

   always @(posedge clk) begin
      if (reset) begin
         rng <= 32'h480b2251;
         app_rdy <= 1'b0;
         app_wdf_rdy <= 1'b0;
         app_rd_data <= '0;
         app_rd_data_valid <= 1'b0;
         wr_cmd_pend <= 1'b0;
         wr_data_pend <= 1'b0;
         rd_busy <= 1'b0;
      end else begin
         rng <= lcg_next(rng);
         // stall about one cycle in four
         app_rdy <= (rng[28:27] != 2'b00);
         app_wdf_rdy <= (rng[25:24] != 2'b00);
         app_rd_data_valid <= 1'b0;
         if (app_en && app_rdy) begin
            if (app_cmd == app_cmd_read) begin
               rd_busy <= 1'b1;
               rd_addr <= app_addr;
               // latency 1 to 8
               rd_count <= rng[19:17];
            end else begin
               wr_cmd_pend <= 1'b1;
               wr_addr <= app_addr;
            end
         end
         if (app_wdf_wren && app_wdf_rdy) begin
            wr_data_pend <= 1'b1;
            wr_data <= app_wdf_data;
         end
         if (wr_cmd_pend && wr_data_pend) begin
            mem[wr_addr] = wr_data;
            wr_cmd_pend <= 1'b0;
            wr_data_pend <= 1'b0;
         end
         if (rd_busy) begin
            if (rd_count == 3'd0) begin
               app_rd_data_valid <= 1'b1;
               app_rd_data <= mem.exists(rd_addr) ? mem[rd_addr] : fill_word(rd_addr);
               rd_busy <= 1'b0;
            end else begin
               rd_count <= rd_count - 3'd1;
            end
         end
      end
   end

endmodule

// File: dv/tb_ram_controller.sv
// testbench for the memory front end, run as top with the DDR model on the application side
`timescale 1ns/1ps
`include "ram_cfg.svh"

module tb_ram_controller
   import ram_pkg::*;
;
   localparam int max_wait = 100;

   logic clk, reset, calib_done;
   logic [`SDRAM_ADDR_W-1:0] sdram_addr;
   logic [`RAM_DATA_W-1:0]   sdram_data_in, sdram_data_out, app_wdf_data, app_rd_data;
   logic sdram_req, sdram_write, sdram_ready, sdram_done;
   logic [`APP_ADDR_W-1:0]   app_addr;
   app_cmd_t app_cmd;
   logic app_en, app_wdf_wren, app_rdy, app_wdf_rdy, app_rd_data_valid;
   logic [`VRAM_ADDR_W-1:0]  vram_cpu_addr, vram_vga_addr;
   logic [`RAM_DATA_W-1:0]   vram_cpu_data_in, vram_cpu_data_out, vram_vga_data_out;
   logic vram_cpu_req, vram_cpu_write, vram_cpu_ready, vram_vga_req, vram_vga_ready;

   int    errors = 0;
   int    tests = 0;
   int    errs_at_start;
   bit    timed_out = 0;
   string test_name = "reset";
   logic [31:0] rand_state = 32'h480b2251;
   logic [31:0] shadow [int];

   ram_controller dut0 (.*);
   ddr_app_model ddr0 (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   ////////////////////////////////////////
   // protocol assertions
   ////////////////////////////////////////

   // ready is the request four clocks back, display one clock back
   assert property (@(posedge clk) disable iff (reset)
      vram_cpu_ready == $past(vram_cpu_req, `VRAM_CPU_DELAY))
      else begin
         $display("ERROR %s vram_cpu_ready expected %b actual %b", test_name,
                  !$sampled(vram_cpu_ready), $sampled(vram_cpu_ready));
         errors++;
      end
   assert property (@(posedge clk) disable iff (reset)
      vram_vga_ready == $past(vram_vga_req, `VRAM_VGA_DELAY))
      else begin
         $display("ERROR %s vram_vga_ready expected %b actual %b", test_name,
                  !$sampled(vram_vga_ready), $sampled(vram_vga_ready));
         errors++;
      end
   // command held with a steady address until taken
   assert property (@(posedge clk) disable iff (reset)
      (app_en && !app_rdy) |=> (app_en && $stable(app_addr)))
      else begin
         $display("%s: app_en dropped or its address moved before app_rdy", test_name);
         errors++;
      end
   // byte address is the word address times four
   assert property (@(posedge clk) disable iff (reset)
      app_en |-> (app_addr == sdram_addr * 4))
      else begin
         $display("ERROR %s app_addr expected %h actual %h", test_name,
                  $sampled(sdram_addr) * 4, $sampled(app_addr));
         errors++;
      end

   ////////////////////////////////////////
   // helpers
   ////////////////////////////////////////

   function automatic logic [31:0] next_random();
      rand_state = rand_state * 32'd1664525 + 32'd1013904223;
      return rand_state;
   endfunction

   // one clock, then inputs move and outputs are settled
   task automatic step();
      @(posedge clk);
      #2;
   endtask

   task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp) else begin
         $display("ERROR %s %s expected %h actual %h", test_name, what, exp, act);
         errors++;
      end
   endtask

   task automatic report_timeout(input string what);
      sdram_state_t st;
      st = dut0.seq0.state;
      $display("%s: timed out waiting for %s, sequencer in %s", test_name, what, st.name());
      timed_out = 1;
      errors++;
   endtask

   task automatic begin_test(input string name);
      test_name = name;
      errs_at_start = errors;
   endtask

   task automatic end_test();
      tests++;
      $display("test %s done with %0d errors", test_name, errors - errs_at_start);
   endtask

   task automatic main_write(input logic [21:0] a, input logic [31:0] d, input bit in_range);
      int n;
      bit saw_en;
      saw_en = 0;
      sdram_addr = a;
      sdram_data_in = d;
      sdram_write = 1'b1;
      for (n = 0; n < max_wait && !sdram_done; n++) begin
         step();
         saw_en |= app_en;
      end
      if (!sdram_done) begin
         report_timeout("sdram_done");
      end else begin
         check_value("app_en seen", in_range, saw_en);
         if (!in_range) check_value("done latency", 2, n);
         sdram_write = 1'b0;
         step();
         check_value("done after release", 0, sdram_done);
      end
   endtask

   task automatic main_read(input logic [21:0] a, input logic [31:0] exp, input bit in_range);
      int n;
      bit saw_valid;
      bit early;
      saw_valid = 0;
      early = 0;
      sdram_addr = a;
      sdram_req = 1'b1;
      for (n = 0; n < max_wait && !sdram_ready; n++) begin
         step();
         early |= sdram_ready && !saw_valid;
         saw_valid |= app_rd_data_valid;
      end
      if (!sdram_ready) begin
         report_timeout("sdram_ready");
      end else begin
         check_value("read data", exp, sdram_data_out);
         if (in_range) check_value("ready before data valid", 0, early);
         else check_value("ready latency", 2, n);
         sdram_req = 1'b0;
         step();
         check_value("ready after release", 0, sdram_ready);
      end
   endtask

   task automatic cpu_access(input logic [14:0] a, input logic [31:0] d, input bit wr,
                             output logic [31:0] rd);
      int n;
      vram_cpu_addr = a;
      vram_cpu_data_in = d;
      vram_cpu_write = wr;
      vram_cpu_req = 1'b1;
      step();
      vram_cpu_req = 1'b0;
      vram_cpu_write = 1'b0;
      for (n = 0; n < max_wait && !vram_cpu_ready; n++) step();
      if (!vram_cpu_ready) report_timeout("vram_cpu_ready");
      rd = vram_cpu_data_out;
   endtask

   task automatic vga_read(input logic [14:0] a, input logic [31:0] exp);
      int n;
      vram_vga_addr = a;
      vram_vga_req = 1'b1;
      step();
      vram_vga_req = 1'b0;
      for (n = 0; n < max_wait && !vram_vga_ready; n++) step();
      if (!vram_vga_ready) begin
         report_timeout("vram_vga_ready");
      end else begin
         check_value("display word", exp, vram_vga_data_out);
         // word held after ready drops
         step();
         check_value("display ready", 0, vram_vga_ready);
         check_value("held word", exp, vram_vga_data_out);
         step();
         check_value("held word later", exp, vram_vga_data_out);
      end
   endtask

   ////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////

   initial begin
      logic [21:0] addrs [20];
      logic [31:0] tmp;
      logic [31:0] rd;
      reset = 1'b1;
      calib_done = 1'b0;
      sdram_addr = '0;
      sdram_data_in = '0;
      sdram_req = 1'b0;
      sdram_write = 1'b0;
      vram_cpu_addr = '0;
      vram_cpu_data_in = '0;
      vram_cpu_req = 1'b0;
      vram_cpu_write = 1'b0;
      vram_vga_addr = '0;
      vram_vga_req = 1'b0;

      begin_test("reset");
      for (int i = 0; i < 5; i++) begin
         step();
         if (i == 3) reset = 1'b0;
         check_value("sdram_ready", 0, sdram_ready);
         check_value("sdram_done", 0, sdram_done);
         check_value("app_en", 0, app_en);
         check_value("app_wdf_wren", 0, app_wdf_wren);
         check_value("vram ready", 0, {vram_cpu_ready, vram_vga_ready});
         check_value("sdram_data_out", 0, sdram_data_out);
         // display shows the cleared hold word
         check_value("display word", 0, vram_vga_data_out);
      end
      calib_done = 1'b1;
      end_test();

      begin_test("in_range");
      for (int i = 0; i < 20 && !timed_out; i++) begin
         tmp = next_random() >> 8;
         addrs[i] = 22'(tmp[`SDRAM_POP_W-1:0]);
         tmp = next_random();
         shadow[int'(addrs[i])] = tmp;
         main_write(addrs[i], tmp, 1);
      end
      for (int i = 0; i < 20 && !timed_out; i++) begin
         main_read(addrs[i], shadow[int'(addrs[i])], 1);
      end
      end_test();

      if (!timed_out) begin
         begin_test("out_of_range");
         main_read(addrs[0] | 22'(1 << `SDRAM_POP_W), 32'hffff_ffff, 0);
         if (!timed_out) main_write(addrs[0] | 22'h20_0000, 32'h1234_5678, 0);
         if (!timed_out) main_read(addrs[0], shadow[int'(addrs[0])], 1);
         end_test();
      end

      if (!timed_out) begin
         begin_test("release");
         // back to back, each access starts right after the last release
         main_write(22'h1_0001, 32'hcafe_0001, 1);
         if (!timed_out) main_read(22'h1_0001, 32'hcafe_0001, 1);
         if (!timed_out) main_write(22'h0_0002, 32'hcafe_0002, 1);
         if (!timed_out) main_read(22'h0_0002, 32'hcafe_0002, 1);
         end_test();
      end

      if (!timed_out) begin
         begin_test("vram_cpu");
         for (int i = 0; i < 6; i++) cpu_access(15'(i * 4099), 32'h5a00_0000 + i, 1, rd);
         for (int i = 0; i < 6; i++) begin
            cpu_access(15'(i * 4099), 0, 0, rd);
            check_value("cpu read", 32'h5a00_0000 + i, rd);
         end
         end_test();
      end

      if (!timed_out) begin
         begin_test("vram_vga");
         vga_read(15'(2 * 4099), 32'h5a00_0002);
         vga_read(15'(5 * 4099), 32'h5a00_0005);
         end_test();
      end

      $display("tests %0d, errors %0d", tests, errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

// File: sim.f
+incdir+include
hdl/ram_pkg.sv
hdl/sdram_sequencer.sv
hdl/vram_dual_port.sv
hdl/ram_controller.sv
dv/ddr_app_model.sv
dv/tb_ram_controller.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     = --binary --timing --assert --timescale 1ns/1ps -Wall -Wno-fatal
TOP       = tb_ram_controller
RTL_TOP   = ram_controller
FILELIST  = sim.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Finished with errors" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Finished with no errors" $(LOG) || (echo "simulation incomplete"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing -Wall --timescale 1ns/1ps --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
